// ==== filelist.f ====
+incdir+include
hdl/fpu_types_pkg.sv
hdl/fpu_ctrl_pkg.sv
hdl/operand_bypass.sv
hdl/fpu_op_decode.sv
hdl/lane_permute_unit.sv
hdl/fpu_result_stage.sv
hdl/fpu_port.sv
tb/fpu_port_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = fpu_port_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/fpu_port_tb.sv ====
`timescale 1ns/100ps
`include "fpu_settings.svh"

module fpu_port_tb
  import fpu_types_pkg::*;
  import fpu_ctrl_pkg::*;
;

  localparam int NUM_ROWS = 24;
  localparam int WATCHDOG_NS = (NUM_ROWS + 20) * 20;
  localparam logic [31:0] SEED = 32'hea3b_c67d;
  localparam fpu_src_t PORT = '0;

  typedef struct packed {
    logic                   idle;
    logic [`FPU_OPC_W-1:0]  opc;
    logic                   use_imm;
    fpu_src_t               src_a;
    fpu_src_t               src_b;
    logic [`FPU_FLAG_W-1:0] raise;
    logic [`FPU_FLAG_W-1:0] csr;
  } row_t;

  typedef struct packed {
    logic [31:0]            row;
    logic                   valid;
    logic [`FPU_DATA_W-1:0] data;
    logic [`FPU_FLAG_W-1:0] flags;
    logic                   ret_en;
    logic [`FPU_CODE_W-1:0] ret_code;
  } exp_t;

  logic                   clk;
  logic                   rst;
  fpu_issue_t             issue;
  fpu_word_u              a;
  fpu_word_u              b;
  fpu_word_u              imm;
  fpu_bus_t               bus;
  logic [`FPU_FLAG_W-1:0] raise;
  fpu_csr_t               csr;
  fpu_result_t            result;
  fpu_ret_t               ret;

  row_t                   rows [NUM_ROWS];
  string                  names [NUM_ROWS];
  logic [`FPU_DATA_W-1:0] a_w [NUM_ROWS];
  logic [`FPU_DATA_W-1:0] b_w [NUM_ROWS];
  logic [`FPU_DATA_W-1:0] imm_w [NUM_ROWS];
  fpu_bus_t               bus_w [NUM_ROWS];
  fpu_bus_t               pre_bus;
  exp_t                   exp_tab [NUM_ROWS];
  exp_t                   expect_q [$];
  logic [31:0]            rng;
  int                     checks = 0;
  int                     errors = 0;

  fpu_port fpu_port_i (
    .clk    (clk),
    .rst    (rst),
    .issue  (issue),
    .a      (a),
    .b      (b),
    .imm    (imm),
    .bus    (bus),
    .raise  (raise),
    .csr    (csr),
    .result (result),
    .ret    (ret)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic rand_word(output logic [`FPU_DATA_W-1:0] w);
    rng = xorshift32(rng);
    w[63:32] = rng;
    rng = xorshift32(rng);
    w[31:0] = rng;
  endtask

  function automatic fpu_src_t bus_src(input logic late, input logic [1:0] idx);
    fpu_src_t s;
    s.use_bus = 1'b1;
    s.late    = late;
    s.bus_idx = idx;
    return s;
  endfunction

  task automatic set_row(input int i, input string name, input logic [7:0] opc,
                         input logic use_imm, input fpu_src_t sa, input fpu_src_t sb,
                         input logic [4:0] fl, input logic [4:0] en, input logic idle);
    names[i] = name;
    rows[i]  = '{idle: idle, opc: opc, use_imm: use_imm, src_a: sa, src_b: sb,
                 raise: fl, csr: en};
  endtask

  task automatic build_table();
    // back to back, no idle cycles
    set_row(0, "and_ports", op_and, 1'b0, PORT, PORT, 5'h00, 5'h1f, 1'b0);
    set_row(1, "or_ports", op_or, 1'b0, PORT, PORT, 5'h00, 5'h1f, 1'b0);
    set_row(2, "xor_ports", op_xor, 1'b0, PORT, PORT, 5'h00, 5'h1f, 1'b0);
    set_row(3, "andn_ports", op_andn, 1'b0, PORT, PORT, 5'h00, 5'h1f, 1'b0);
    set_row(4, "copy_a_ports", op_copy_a, 1'b0, PORT, PORT, 5'h00, 5'h1f, 1'b0);
    set_row(5, "copy_b_ports", op_copy_b, 1'b0, PORT, PORT, 5'h00, 5'h1f, 1'b0);
    set_row(6, "swap_ports", op_swap, 1'b0, PORT, PORT, 5'h00, 5'h1f, 1'b0);
    set_row(7, "dup_lo_ports", op_dup_lo, 1'b0, PORT, PORT, 5'h00, 5'h1f, 1'b0);
    set_row(8, "idle_gap", 8'h00, 1'b0, PORT, PORT, 5'h00, 5'h00, 1'b1);
    // forwarding from the buses
    set_row(9, "copy_a_bus0_now", op_copy_a, 1'b0, bus_src(1'b0, 2'd0), PORT,
            5'h00, 5'h00, 1'b0);
    set_row(10, "copy_a_bus3_now", op_copy_a, 1'b0, bus_src(1'b0, 2'd3), PORT,
            5'h00, 5'h00, 1'b0);
    set_row(11, "copy_b_bus2_late", op_copy_b, 1'b0, PORT, bus_src(1'b1, 2'd2),
            5'h00, 5'h00, 1'b0);
    set_row(12, "xor_late1_now1", op_xor, 1'b0, bus_src(1'b1, 2'd1), bus_src(1'b0, 2'd1),
            5'h00, 5'h00, 1'b0);
    set_row(13, "and_imm", op_and, 1'b1, PORT, bus_src(1'b0, 2'd3), 5'h00, 5'h00, 1'b0);
    set_row(14, "swap_imm", op_swap, 1'b1, PORT, PORT, 5'h00, 5'h00, 1'b0);
    set_row(15, "idle_mid", 8'h00, 1'b0, PORT, PORT, 5'h00, 5'h00, 1'b1);
    // exception flags against csr masks
    set_row(16, "flag_low_enabled", op_copy_a, 1'b0, PORT, PORT, 5'h01, 5'h1f, 1'b0);
    set_row(17, "flag_masked", op_copy_b, 1'b0, PORT, PORT, 5'h04, 5'h1b, 1'b0);
    set_row(18, "flags_all_en", op_or, 1'b0, PORT, PORT, 5'h16, 5'h1f, 1'b0);
    set_row(19, "flags_mask_upper", op_or, 1'b0, PORT, PORT, 5'h16, 5'h1c, 1'b0);
    set_row(20, "flags_mask_top", op_or, 1'b0, PORT, PORT, 5'h16, 5'h10, 1'b0);
    set_row(21, "unknown_opcode", 8'h55, 1'b0, PORT, PORT, 5'h08, 5'h08, 1'b0);
    set_row(22, "dup_lo_bus0_late", op_dup_lo, 1'b0, bus_src(1'b1, 2'd0), PORT,
            5'h02, 5'h1f, 1'b0);
    // idle right after a flagged op, the held flags must not report
    set_row(23, "idle_end", 8'h00, 1'b0, PORT, PORT, 5'h00, 5'h1f, 1'b1);
  endtask

  task automatic gen_data();
    logic [`FPU_DATA_W-1:0] w;
    for (int j = 0; j < `FPU_NUM_BUSES; j++) begin
      rand_word(w);
      pre_bus[j] = w;
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      rand_word(a_w[i]);
      rand_word(b_w[i]);
      rand_word(imm_w[i]);
      for (int j = 0; j < `FPU_NUM_BUSES; j++) begin
        rand_word(w);
        bus_w[i][j] = w;
      end
    end
  endtask

  function automatic logic [63:0] operand(input fpu_src_t s, input logic [63:0] port_w,
                                          input fpu_bus_t now_b, input fpu_bus_t prev_b);
    if (!s.use_bus) begin
      return port_w;
    end
    if (s.late) begin
      return prev_b[s.bus_idx];
    end
    return now_b[s.bus_idx];
  endfunction

  function automatic logic [63:0] expected_data(input logic [7:0] opc, input logic [63:0] x,
                                                input logic [63:0] y);
    case (opc)
      op_copy_a: return x;
      op_copy_b: return y;
      op_swap:   return {y[31:0], y[63:32]};
      op_dup_lo: return {x[31:0], x[31:0]};
      op_and:    return x & y;
      op_or:     return x | y;
      op_xor:    return x ^ y;
      op_andn:   return x & ~y;
      default:   return 64'h0;
    endcase
  endfunction

  task automatic build_model();
    fpu_bus_t               prev;
    logic [63:0]            x;
    logic [63:0]            y;
    logic [4:0]             m;
    logic                   found;
    for (int i = 0; i < NUM_ROWS; i++) begin
      prev = (i == 0) ? pre_bus : bus_w[i-1];
      x = operand(rows[i].src_a, a_w[i], bus_w[i], prev);
      y = rows[i].use_imm ? imm_w[i] : operand(rows[i].src_b, b_w[i], bus_w[i], prev);
      m = rows[i].raise & rows[i].csr;
      exp_tab[i].row      = 32'(i);
      exp_tab[i].valid    = !rows[i].idle;
      exp_tab[i].data     = expected_data(rows[i].opc, x, y);
      exp_tab[i].flags    = rows[i].raise;
      exp_tab[i].ret_en   = !rows[i].idle && (m != 5'h00);
      exp_tab[i].ret_code = 3'd0;
      found = 1'b0;
      for (int k = 0; k < `FPU_FLAG_W; k++) begin
        if (exp_tab[i].ret_en && m[k] && !found) begin
          exp_tab[i].ret_code = 3'(k);
          found = 1'b1;
        end
      end
    end
  endtask

  task automatic drive_row(input int i);
    issue.en      = !rows[i].idle;
    issue.opcode  = fpu_opcode_e'(rows[i].opc);
    issue.use_imm = rows[i].use_imm;
    issue.src_a   = rows[i].src_a;
    issue.src_b   = rows[i].src_b;
    a             = a_w[i];
    b             = b_w[i];
    imm           = imm_w[i];
    bus           = bus_w[i];
    raise         = rows[i].raise;
  endtask

  task automatic check_quiet(input string name);
    checks++;
    assert (result.valid === 1'b0 && ret.en === 1'b0) else begin
      errors++;
      $display("FAILED %s: expected valid 0 ret.en 0, actual valid %b ret.en %b",
               name, result.valid, ret.en);
    end
  endtask

  task automatic check_out(input exp_t e);
    string name;
    name = names[e.row];
    checks++;
    assert (result.valid === e.valid) else begin
      errors++;
      $display("FAILED %s valid: expected %b, actual %b", name, e.valid, result.valid);
    end
    assert (ret === {e.ret_en, e.ret_code}) else begin
      errors++;
      $display("FAILED %s ret: expected en %b code %0d, actual en %b code %0d",
               name, e.ret_en, e.ret_code, ret.en, ret.code);
    end
    if (e.valid) begin
      assert (result.data === e.data) else begin
        errors++;
        $display("FAILED %s data: expected %h, actual %h", name, e.data, result.data);
      end
      assert (result.flags === e.flags) else begin
        errors++;
        $display("FAILED %s flags: expected %b, actual %b", name, e.flags, result.flags);
      end
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: timeout, the run did not complete within %0d ns", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

  initial begin
    exp_t e;
    rng = SEED;
    build_table();
    gen_data();
    build_model();
    rst   = 1'b1;
    issue = '0;
    a     = '0;
    b     = '0;
    imm   = '0;
    bus   = pre_bus;
    raise = '0;
    csr   = '0;
    repeat (8) begin
      @(negedge clk);
      check_quiet("reset");
    end
    rst = 1'b0;
    // result of row n shows up three falling edges after it was driven
    for (int cyc = 0; cyc < NUM_ROWS + 3; cyc++) begin
      @(negedge clk);
      if (cyc >= 3) begin
        e = expect_q.pop_front();
        check_out(e);
      end else begin
        check_quiet("pipeline_fill");
      end
      if (cyc < NUM_ROWS) begin
        drive_row(cyc);
        expect_q.push_back(exp_tab[cyc]);
      end else begin
        issue = '0;
      end
      // csr is read as the result leaves, two cycles after issue
      if (cyc >= 2 && cyc - 2 < NUM_ROWS) begin
        csr.en = rows[cyc-2].csr;
      end else begin
        csr = '0;
      end
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== hdl/fpu_port.sv ====
`timescale 1ns/100ps
`include "fpu_settings.svh"

module fpu_port
  import fpu_types_pkg::*;
  import fpu_ctrl_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  fpu_issue_t             issue,
  input  fpu_word_u              a,
  input  fpu_word_u              b,
  input  fpu_word_u              imm,
  input  fpu_bus_t               bus,
  input  logic [`FPU_FLAG_W-1:0] raise,
  input  fpu_csr_t               csr,
  output fpu_result_t            result,
  output fpu_ret_t               ret
);

  fpu_word_u op_a;
  fpu_word_u op_b;
  fpu_ctrl_t dec_ctrl;
  fpu_word_u perm_data;
  fpu_ctrl_t perm_ctrl;

  // E0 operand capture
  operand_bypass operand_bypass_i (
    .clk   (clk),
    .rst   (rst),
    .issue (issue),
    .a     (a),
    .b     (b),
    .imm   (imm),
    .bus   (bus),
    .op_a  (op_a),
    .op_b  (op_b)
  );

  fpu_op_decode fpu_op_decode_i (
    .clk   (clk),
    .rst   (rst),
    .issue (issue),
    .raise (raise),
    .ctrl  (dec_ctrl)
  );

  // E1
  lane_permute_unit lane_permute_unit_i (
    .clk      (clk),
    .rst      (rst),
    .op_a     (op_a),
    .op_b     (op_b),
    .ctrl     (dec_ctrl),
    .data     (perm_data),
    .ctrl_out (perm_ctrl)
  );

  // E2 result and exception report
  fpu_result_stage fpu_result_stage_i (
    .clk    (clk),
    .rst    (rst),
    .data   (perm_data),
    .ctrl   (perm_ctrl),
    .csr    (csr),
    .result (result),
    .ret    (ret)
  );

endmodule

// ==== hdl/fpu_result_stage.sv ====
`timescale 1ns/100ps
`include "fpu_settings.svh"

module fpu_result_stage
  import fpu_types_pkg::*;
  import fpu_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  fpu_word_u   data,
  input  fpu_ctrl_t   ctrl,
  input  fpu_csr_t    csr,
  output fpu_result_t result,
  output fpu_ret_t    ret
);

  logic [`FPU_FLAG_W-1:0] masked;
  logic [`FPU_CODE_W-1:0] low_code;
  logic                   hit;

  always_comb begin
    masked   = ctrl.raise & csr.en;
    hit      = ctrl.valid && (|masked);
    low_code = '0;
    // scan down so the lowest set bit is the one kept
    for (int i = `FPU_FLAG_W - 1; i >= 0; i--) begin
      if (masked[i]) begin
        low_code = `FPU_CODE_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result.valid <= 1'b0;
      ret          <= '0;
    end else begin
      result.valid <= ctrl.valid;
      ret.en       <= hit;
      if (hit) begin
        ret.code <= low_code;
      end else begin
        ret.code <= '0;
      end
    end
  end

  // flags go out unmasked
  always_ff @(posedge clk) begin
    result.data  <= data;
    result.flags <= ctrl.raise;
  end

  a_ret_needs_valid: assert property (@(posedge clk) disable iff (rst)
    ret.en |-> result.valid);

endmodule

// ==== hdl/lane_permute_unit.sv ====
`timescale 1ns/100ps

module lane_permute_unit
  import fpu_types_pkg::*;
  import fpu_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  fpu_word_u op_a,
  input  fpu_word_u op_b,
  input  fpu_ctrl_t ctrl,
  output fpu_word_u data,
  output fpu_ctrl_t ctrl_out
);

  fpu_word_u res;

  always_comb begin
    res = '0;
    if (ctrl.logic_en) begin
      // bitwise ops on the double view
      case (ctrl.logic_sel)
        2'd0: res.dbl = op_a.dbl & op_b.dbl;
        2'd1: res.dbl = op_a.dbl | op_b.dbl;
        2'd2: res.dbl = op_a.dbl ^ op_b.dbl;
        default: res.dbl = op_a.dbl & ~op_b.dbl;
      endcase
    end else begin
      case (ctrl.perm_sel)
        perm_copy: begin
          if (ctrl.logic_sel[0]) begin
            res = op_b;
          end else begin
            res = op_a;
          end
        end
        perm_swap: begin
          res.lane.hi = op_b.lane.lo;
          res.lane.lo = op_b.lane.hi;
        end
        perm_dup_lo: begin
          res.lane.hi = op_a.lane.lo;
          res.lane.lo = op_a.lane.lo;
        end
        default: begin
          res = '0;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.valid) begin
      data <= res;
    end
  end

  // valid and raise follow the data down one stage
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_out <= '0;
    end else begin
      ctrl_out <= ctrl;
    end
  end

endmodule

// ==== hdl/fpu_op_decode.sv ====
`timescale 1ns/100ps
`include "fpu_settings.svh"

module fpu_op_decode
  import fpu_ctrl_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  fpu_issue_t             issue,
  input  logic [`FPU_FLAG_W-1:0] raise,
  output fpu_ctrl_t              ctrl
);

  logic      dec_logic_en;
  logic [1:0] dec_logic_sel;
  fpu_perm_e dec_perm;

  always_comb begin
    dec_logic_en  = 1'b0;
    dec_logic_sel = 2'd0;
    dec_perm      = perm_none;
    case (issue.opcode)
      op_copy_a: begin
        dec_perm = perm_copy;
      end
      op_copy_b: begin
        dec_perm      = perm_copy;
        dec_logic_sel = 2'd1;
      end
      op_swap: begin
        dec_perm = perm_swap;
      end
      op_dup_lo: begin
        dec_perm = perm_dup_lo;
      end
      op_and, op_or, op_xor, op_andn: begin
        dec_logic_en  = 1'b1;
        dec_logic_sel = issue.opcode[1:0];
      end
      // unknown codes leave everything off, zero result
      default: begin
        dec_perm = perm_none;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl <= '0;
    end else begin
      ctrl.valid <= issue.en;
      if (issue.en) begin
        ctrl.logic_en  <= dec_logic_en;
        ctrl.logic_sel <= dec_logic_sel;
        ctrl.perm_sel  <= dec_perm;
        ctrl.raise     <= raise;
      end
    end
  end

  a_logic_no_perm: assert property (@(posedge clk) disable iff (rst)
    ctrl.logic_en |-> ctrl.perm_sel == perm_none);

endmodule

// ==== hdl/operand_bypass.sv ====
`timescale 1ns/100ps
`include "fpu_settings.svh"

module operand_bypass
  import fpu_types_pkg::*;
  import fpu_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  fpu_issue_t issue,
  input  fpu_word_u  a,
  input  fpu_word_u  b,
  input  fpu_word_u  imm,
  input  fpu_bus_t   bus,
  output fpu_word_u  op_a,
  output fpu_word_u  op_b
);

  // bus contents one cycle back, source for late forwarding
  fpu_bus_t  bus_q;
  fpu_word_u sel_a;
  fpu_word_u sel_b;

  function automatic fpu_word_u pick_src(
    input fpu_src_t  src,
    input fpu_word_u port_word,
    input fpu_bus_t  now,
    input fpu_bus_t  prev
  );
    if (!src.use_bus) begin
      return port_word;
    end else if (src.late) begin
      return prev[src.bus_idx];
    end else begin
      return now[src.bus_idx];
    end
  endfunction

  always_comb begin
    sel_a = pick_src(issue.src_a, a, bus, bus_q);
    // immediate overrides the whole B source
    if (issue.use_imm) begin
      sel_b = imm;
    end else begin
      sel_b = pick_src(issue.src_b, b, bus, bus_q);
    end
  end

  always_ff @(posedge clk) begin
    bus_q <= bus;
    if (issue.en) begin
      op_a <= sel_a;
      op_b <= sel_b;
    end
  end

  a_src_a_idx: assert property (@(posedge clk) disable iff (rst)
    issue.en && issue.src_a.use_bus |-> issue.src_a.bus_idx < `FPU_NUM_BUSES);

  a_src_b_idx: assert property (@(posedge clk) disable iff (rst)
    issue.en && !issue.use_imm && issue.src_b.use_bus
      |-> issue.src_b.bus_idx < `FPU_NUM_BUSES);

endmodule

// ==== hdl/fpu_ctrl_pkg.sv ====
`include "fpu_settings.svh"

package fpu_ctrl_pkg;

  // logic group shares the upper bits, low two bits pick the function
  typedef enum logic [`FPU_OPC_W-1:0] {
    op_copy_a = 8'h00,
    op_copy_b = 8'h01,
    op_swap   = 8'h02,
    op_dup_lo = 8'h03,
    op_and    = 8'h10,
    op_or     = 8'h11,
    op_xor    = 8'h12,
    op_andn   = 8'h13
  } fpu_opcode_e;

  typedef enum logic [1:0] {
    perm_none   = 2'd0,
    perm_copy   = 2'd1,
    perm_swap   = 2'd2,
    perm_dup_lo = 2'd3
  } fpu_perm_e;

  typedef struct packed {
    logic                      use_bus;
    logic                      late;
    logic [`FPU_BUS_IDX_W-1:0] bus_idx;
  } fpu_src_t;

  typedef struct packed {
    logic        en;
    fpu_opcode_e opcode;
    logic        use_imm;
    fpu_src_t    src_a;
    fpu_src_t    src_b;
  } fpu_issue_t;

  // logic_sel doubles as copy source select while logic_en is low
  typedef struct packed {
    logic                   valid;
    logic                   logic_en;
    logic [1:0]             logic_sel;
    fpu_perm_e              perm_sel;
    logic [`FPU_FLAG_W-1:0] raise;
  } fpu_ctrl_t;

  typedef struct packed {
    logic [`FPU_FLAG_W-1:0] en;
  } fpu_csr_t;

  typedef struct packed {
    logic                   en;
    logic [`FPU_CODE_W-1:0] code;
  } fpu_ret_t;

endpackage

// ==== hdl/fpu_types_pkg.sv ====
`include "fpu_settings.svh"

package fpu_types_pkg;

  // single lane view, hi lane in the upper half
  typedef struct packed {
    logic [`FPU_LANE_W-1:0] hi;
    logic [`FPU_LANE_W-1:0] lo;
  } fpu_lanes_t;

  // logic ops read dbl, permute ops read lane
  typedef union packed {
    logic [`FPU_DATA_W-1:0] dbl;
    fpu_lanes_t             lane;
  } fpu_word_u;

  typedef fpu_word_u [`FPU_NUM_BUSES-1:0] fpu_bus_t;

  typedef struct packed {
    logic                   valid;
    fpu_word_u              data;
    logic [`FPU_FLAG_W-1:0] flags;
  } fpu_result_t;

endpackage

// ==== include/fpu_settings.svh ====
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// operand word, seen as one double or two single lanes
`define FPU_DATA_W 64
`define FPU_LANE_W 32

// forwarded result buses
`define FPU_NUM_BUSES 4
`define FPU_BUS_IDX_W 2

// exception flags and the code that names one of them
`define FPU_FLAG_W 5
`define FPU_CODE_W 3

`define FPU_OPC_W 8

`endif
